/* Makefile */
SIM      := verilator
FLAGS    := --binary
TOP      := tb_noc_mesh
FILELIST := list.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/noc_link_if.sv */
/* NoC link
 * one flit channel with valid/ready flow control
 */
`timescale 1ns/1ps
`default_nettype none

interface noc_link_if;
   import noc_pkg::*;

   flit_t flit;
   logic  last;
   logic  valid;
   logic  ready;

   // sender side
   modport tx (
      output flit,
      output last,
      output valid,
      input  ready
   );

   // receiver side
   modport rx (
      input  flit,
      input  last,
      input  valid,
      output ready
   );

endinterface

`default_nettype wire

/* common/noc_pkg.sv */
/* NoC shared definitions
 * mesh geometry, flit layout, port numbering and the router types
 */
`default_nettype none

package noc_pkg;

   // grid geometry
   localparam int MESH_X = 2;
   localparam int MESH_Y = 2;
   localparam int NODES  = MESH_X * MESH_Y;
   localparam int NODE_W = $clog2(NODES);

   // flit layout, destination sits in the top bits of a head flit
   localparam int FLIT_W   = 32;
   localparam int DEST_MSB = FLIT_W - 1;

   localparam int BUF_DEPTH = 4;
   localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

   localparam int PORTS      = 5;
   localparam int PORT_IDX_W = $clog2(PORTS);

   // port indices into the router link arrays
   localparam int PORT_LOCAL = 0;
   localparam int PORT_NORTH = 1;
   localparam int PORT_EAST  = 2;
   localparam int PORT_SOUTH = 3;
   localparam int PORT_WEST  = 4;

   typedef logic [FLIT_W-1:0]     flit_t;
   typedef logic [NODE_W-1:0]     node_t;
   typedef logic [PORTS-1:0]      port_sel_t;
   typedef logic [PORT_IDX_W-1:0] port_idx_t;
   typedef logic [BUF_PTR_W-1:0]  buf_ptr_t;
   typedef logic [BUF_PTR_W:0]    buf_cnt_t;

   // one-hot direction codes, bit position equals the port index
   localparam port_sel_t DIR_LOCAL = port_sel_t'(1) << PORT_LOCAL;
   localparam port_sel_t DIR_NORTH = port_sel_t'(1) << PORT_NORTH;
   localparam port_sel_t DIR_EAST  = port_sel_t'(1) << PORT_EAST;
   localparam port_sel_t DIR_SOUTH = port_sel_t'(1) << PORT_SOUTH;
   localparam port_sel_t DIR_WEST  = port_sel_t'(1) << PORT_WEST;

   // output stage FSM
   typedef enum logic {
      IDLE,
      LOCKED
   } arb_state_e;

endpackage

`default_nettype wire

/* hw/noc_mesh.sv */
/* NoC mesh top level
 * grid of XY routers, neighbor links and border tie-offs
 */
`timescale 1ns/1ps
`default_nettype none

module noc_mesh (
   input  logic                                clk,
   input  logic                                arst_n,
   input  noc_pkg::flit_t [noc_pkg::NODES-1:0] in_flit,
   input  logic [noc_pkg::NODES-1:0]           in_last,
   input  logic [noc_pkg::NODES-1:0]           in_valid,
   output logic [noc_pkg::NODES-1:0]           in_ready,
   output noc_pkg::flit_t [noc_pkg::NODES-1:0] out_flit,
   output logic [noc_pkg::NODES-1:0]           out_last,
   output logic [noc_pkg::NODES-1:0]           out_valid,
   input  logic [noc_pkg::NODES-1:0]           out_ready
);
   import noc_pkg::*;

   // per node, per port wiring, north is y+1 and east is x+1
   wire flit_t [PORTS-1:0] nd_in_flit [NODES];
   wire [PORTS-1:0]        nd_in_last [NODES];
   wire [PORTS-1:0]        nd_in_valid [NODES];
   wire [PORTS-1:0]        nd_in_ready [NODES];
   wire flit_t [PORTS-1:0] nd_out_flit [NODES];
   wire [PORTS-1:0]        nd_out_last [NODES];
   wire [PORTS-1:0]        nd_out_valid [NODES];
   wire [PORTS-1:0]        nd_out_ready [NODES];

   function automatic bit has_nb(input int x, input int y, input int d);
      return (d == PORT_NORTH) ? (y < MESH_Y - 1) :
             (d == PORT_EAST)  ? (x < MESH_X - 1) :
             (d == PORT_SOUTH) ? (y > 0) : (x > 0);
   endfunction

   function automatic int nb_node(input int x, input int y, input int d);
      return (d == PORT_NORTH) ? x + (y + 1) * MESH_X :
             (d == PORT_EAST)  ? (x + 1) + y * MESH_X :
             (d == PORT_SOUTH) ? x + (y - 1) * MESH_X : (x - 1) + y * MESH_X;
   endfunction

   // north faces south, east faces west
   function automatic int opposite(input int d);
      return ((d + 1) % 4) + 1;
   endfunction

   for (genvar y = 0; y < MESH_Y; y++) begin : g_y
      for (genvar x = 0; x < MESH_X; x++) begin : g_x
         localparam int n = x + y * MESH_X;

         noc_link_if rin [PORTS] ();
         noc_link_if rout [PORTS] ();

         noc_router #(
            .node_x (x),
            .node_y (y)
         ) u_router (
            .clk      (clk),
            .arst_n   (arst_n),
            .link_in  (rin),
            .link_out (rout)
         );

         for (genvar p = 0; p < PORTS; p++) begin : g_port
            assign rin[p].flit        = nd_in_flit[n][p];
            assign rin[p].last        = nd_in_last[n][p];
            assign rin[p].valid       = nd_in_valid[n][p];
            assign nd_in_ready[n][p]  = rin[p].ready;
            assign nd_out_flit[n][p]  = rout[p].flit;
            assign nd_out_last[n][p]  = rout[p].last;
            assign nd_out_valid[n][p] = rout[p].valid;
            assign rout[p].ready      = nd_out_ready[n][p];
         end

         // local port goes to the top level
         assign nd_in_flit[n][PORT_LOCAL]   = in_flit[n];
         assign nd_in_last[n][PORT_LOCAL]   = in_last[n];
         assign nd_in_valid[n][PORT_LOCAL]  = in_valid[n];
         assign in_ready[n]                 = nd_in_ready[n][PORT_LOCAL];
         assign out_flit[n]                 = nd_out_flit[n][PORT_LOCAL];
         assign out_last[n]                 = nd_out_last[n][PORT_LOCAL];
         assign out_valid[n]                = nd_out_valid[n][PORT_LOCAL];
         assign nd_out_ready[n][PORT_LOCAL] = out_ready[n];

         for (genvar d = PORT_NORTH; d <= PORT_WEST; d++) begin : g_dir
            if (has_nb(x, y, d)) begin : g_link
               assign nd_in_flit[n][d]   = nd_out_flit[nb_node(x, y, d)][opposite(d)];
               assign nd_in_last[n][d]   = nd_out_last[nb_node(x, y, d)][opposite(d)];
               assign nd_in_valid[n][d]  = nd_out_valid[nb_node(x, y, d)][opposite(d)];
               assign nd_out_ready[n][d] = nd_in_ready[nb_node(x, y, d)][opposite(d)];
            end else begin : g_tie
               assign nd_in_flit[n][d]   = '0;
               assign nd_in_last[n][d]   = 1'b0;
               assign nd_in_valid[n][d]  = 1'b0;
               assign nd_out_ready[n][d] = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* list.f */
common/noc_pkg.sv
common/noc_link_if.sv
router/noc_input_buffer.sv
router/noc_output_arbiter.sv
router/noc_router.sv
hw/noc_mesh.sv
testbench/noc_checker.sv
testbench/tb_noc_mesh.sv

/* router/noc_input_buffer.sv */
/* NoC router input stage
 * flit FIFO plus XY route decision, held from head flit to last flit
 */
`timescale 1ns/1ps
`default_nettype none

module noc_input_buffer #(
   parameter int node_x = 0,
   parameter int node_y = 0
) (
   input  logic               clk,
   input  logic               arst_n,
   noc_link_if.rx             in,
   output noc_pkg::flit_t     head_flit,
   output logic               head_last,
   output noc_pkg::port_sel_t req,
   input  logic               grant
);
   import noc_pkg::*;

   flit_t                mem [BUF_DEPTH];
   logic [BUF_DEPTH-1:0] last_mem;
   buf_ptr_t             wr_ptr;
   buf_ptr_t             rd_ptr;
   buf_cnt_t             count;
   logic                 push;
   logic                 pop;
   logic                 empty;
   logic                 in_pkt;
   port_sel_t            route_q;
   port_sel_t            route_new;
   node_t                dest;

   function automatic buf_ptr_t next_ptr(input buf_ptr_t ptr);
      return (ptr == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty    = (count == '0);
   assign in.ready = (count != buf_cnt_t'(BUF_DEPTH));
   assign push     = in.valid && in.ready;
   // arbiter grants only a requesting input, so the FIFO is never empty here
   assign pop      = grant;

   assign head_flit = mem[rd_ptr];
   assign head_last = last_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr]      <= in.flit;
         last_mem[wr_ptr] <= in.last;
      end
   end

   // dimension order: fix X first, then Y
   assign dest = head_flit[DEST_MSB -: NODE_W];

   always_comb begin
      int dx;
      int dy;
      dx = int'(dest) % MESH_X;
      dy = int'(dest) / MESH_X;
      if (dx > node_x)
         route_new = DIR_EAST;
      else if (dx < node_x)
         route_new = DIR_WEST;
      else if (dy > node_y)
         route_new = DIR_NORTH;
      else if (dy < node_y)
         route_new = DIR_SOUTH;
      else
         route_new = DIR_LOCAL;
   end

   // body flits follow the direction latched at the head
   assign req = empty ? '0 : (in_pkt ? route_q : route_new);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         in_pkt  <= 1'b0;
         route_q <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + buf_cnt_t'(push) - buf_cnt_t'(pop);

         if (pop) begin
            if (head_last) begin
               in_pkt <= 1'b0;
            end else if (!in_pkt) begin
               in_pkt  <= 1'b1;
               route_q <= route_new;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* router/noc_output_arbiter.sv */
/* NoC router output stage
 * round-robin arbiter locked per packet, feeding a registered output slot
 */
`timescale 1ns/1ps
`default_nettype none

module noc_output_arbiter (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic [noc_pkg::PORTS-1:0]           req,
   input  noc_pkg::flit_t [noc_pkg::PORTS-1:0] head_flit,
   input  logic [noc_pkg::PORTS-1:0]           head_last,
   output logic [noc_pkg::PORTS-1:0]           grant,
   noc_link_if.tx                              out
);
   import noc_pkg::*;

   arb_state_e state;
   port_idx_t  owner;
   port_idx_t  winner;
   logic       found;
   logic       slot_free;
   logic       fwd;
   flit_t      slot_flit;
   logic       slot_last;
   logic       slot_valid;

   // slot takes a new flit when empty or draining this cycle
   assign slot_free = !slot_valid || out.ready;
   assign fwd       = (state == LOCKED) && req[owner] && slot_free;

   // search starts one past the previous owner
   always_comb begin
      int idx;
      winner = owner;
      found  = 1'b0;
      for (int i = 1; i <= PORTS; i++) begin
         idx = (int'(owner) + i) % PORTS;
         if (!found && req[idx]) begin
            winner = port_idx_t'(idx);
            found  = 1'b1;
         end
      end
   end

   always_comb begin
      grant        = '0;
      grant[owner] = fwd;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= IDLE;
         owner      <= '0;
         slot_valid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (found) begin
                  owner <= winner;
                  state <= LOCKED;
               end
            end
            LOCKED: begin
               // release only once the tail has gone into the slot
               if (fwd && head_last[owner])
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase

         if (fwd)
            slot_valid <= 1'b1;
         else if (out.ready)
            slot_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fwd) begin
         slot_flit <= head_flit[owner];
         slot_last <= head_last[owner];
      end
   end

   assign out.flit  = slot_flit;
   assign out.last  = slot_last;
   assign out.valid = slot_valid;

endmodule

`default_nettype wire

/* router/noc_router.sv */
/* NoC router
 * five ports, input FIFOs with XY routing and per-output packet arbiters
 */
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
   parameter int node_x = 0,
   parameter int node_y = 0
) (
   input  logic   clk,
   input  logic   arst_n,
   noc_link_if.rx link_in [noc_pkg::PORTS],
   noc_link_if.tx link_out [noc_pkg::PORTS]
);
   import noc_pkg::*;

   flit_t [PORTS-1:0]           head_flit;
   logic [PORTS-1:0]            head_last;
   port_sel_t [PORTS-1:0]       in_req;
   logic [PORTS-1:0]            in_grant;
   // indexed [output][input]
   logic [PORTS-1:0][PORTS-1:0] out_req;
   logic [PORTS-1:0][PORTS-1:0] out_grant;

   for (genvar i = 0; i < PORTS; i++) begin : g_in
      logic [PORTS-1:0] grant_seen;

      noc_input_buffer #(
         .node_x (node_x),
         .node_y (node_y)
      ) u_buf (
         .clk       (clk),
         .arst_n    (arst_n),
         .in        (link_in[i]),
         .head_flit (head_flit[i]),
         .head_last (head_last[i]),
         .req       (in_req[i]),
         .grant     (in_grant[i])
      );

      for (genvar o = 0; o < PORTS; o++) begin : g_xpose
         assign out_req[o][i]  = in_req[i][o];
         assign grant_seen[o]  = out_grant[o][i];
      end

      // only the arbiter of the requested direction counts
      assign in_grant[i] = |(grant_seen & in_req[i]);
   end

   for (genvar o = 0; o < PORTS; o++) begin : g_out
      noc_output_arbiter u_arb (
         .clk       (clk),
         .arst_n    (arst_n),
         .req       (out_req[o]),
         .head_flit (head_flit),
         .head_last (head_last),
         .grant     (out_grant[o]),
         .out       (link_out[o])
      );
   end

endmodule

`default_nettype wire

/* testbench/noc_checker.sv */
/* NoC mesh scoreboard
 * tracks accepted flits per source and destination pair and checks every delivered flit
 */
`timescale 1ns/1ps
`default_nettype none

module noc_checker #(
   parameter int SRC_LSB = 28
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  noc_pkg::flit_t [noc_pkg::NODES-1:0] in_flit,
   input  logic [noc_pkg::NODES-1:0]           in_last,
   input  logic [noc_pkg::NODES-1:0]           in_valid,
   input  logic [noc_pkg::NODES-1:0]           in_ready,
   input  noc_pkg::flit_t [noc_pkg::NODES-1:0] out_flit,
   input  logic [noc_pkg::NODES-1:0]           out_last,
   input  logic [noc_pkg::NODES-1:0]           out_valid,
   input  logic [noc_pkg::NODES-1:0]           out_ready,
   output int                                  errors,
   output int                                  pending,
   output int                                  delivered
);
   import noc_pkg::*;

   // queue src * NODES + dst holds the expected {last, flit} words
   logic [FLIT_W:0]  exp_q [NODES*NODES][$];
   node_t            open_dest [NODES];
   logic [NODES-1:0] src_open;
   node_t            open_src [NODES];
   logic [NODES-1:0] dst_open;

   always @(posedge clk or negedge arst_n) begin
      int              d;
      int              s;
      logic [FLIT_W:0] exp;
      if (!arst_n) begin
         errors    = 0;
         pending   = 0;
         delivered = 0;
         src_open  = '0;
         dst_open  = '0;
         for (int i = 0; i < NODES * NODES; i++)
            exp_q[i].delete();
      end else begin
         // body flits go where their head went
         for (int n = 0; n < NODES; n++) begin
            if (in_valid[n] && in_ready[n]) begin
               d = src_open[n] ? int'(open_dest[n]) : int'(in_flit[n][DEST_MSB -: NODE_W]);
               exp_q[n * NODES + d].push_back({in_last[n], in_flit[n]});
               pending++;
               open_dest[n] = node_t'(d);
               src_open[n]  = !in_last[n];
            end
         end
         for (int n = 0; n < NODES; n++) begin
            if (out_valid[n] && out_ready[n]) begin
               if (!dst_open[n]) begin
                  open_src[n] = out_flit[n][SRC_LSB +: NODE_W];
                  if (out_flit[n][DEST_MSB -: NODE_W] != node_t'(n)) begin
                     errors++;
                     $display("[FAIL] out_flit[%0d] dest field got %h expected %h",
                              n, out_flit[n][DEST_MSB -: NODE_W], node_t'(n));
                  end
               end
               s           = int'(open_src[n]);
               dst_open[n] = !out_last[n];
               if (exp_q[s * NODES + n].size() == 0) begin
                  errors++;
                  $display("unexpected flit at node %0d, nothing was sent from node %0d", n, s);
               end else begin
                  exp = exp_q[s * NODES + n].pop_front();
                  pending--;
                  delivered++;
                  if ({out_last[n], out_flit[n]} != exp) begin
                     errors++;
                     $display(
                        "[FAIL] node %0d out_flit got %h expected %h, out_last got %h expected %h",
                        n, out_flit[n], exp[FLIT_W-1:0], out_last[n], exp[FLIT_W]);
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_noc_mesh.sv */
/* NoC mesh testbench
 * LFSR packet traffic from every node, delivery checked by the scoreboard module
 */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_mesh;
   import noc_pkg::*;

   // test payload: head has dest, source, sequence; body has sequence and flit index
   localparam int SRC_LSB    = DEST_MSB - 2 * NODE_W + 1;
   localparam int SEQ_LSB    = SRC_LSB - 8;
   localparam int STEP_LIMIT = 20000;

   logic              clk;
   logic              arst_n;
   flit_t [NODES-1:0] in_flit;
   logic [NODES-1:0]  in_last;
   logic [NODES-1:0]  in_valid;
   logic [NODES-1:0]  in_ready;
   flit_t [NODES-1:0] out_flit;
   logic [NODES-1:0]  out_last;
   logic [NODES-1:0]  out_valid;
   logic [NODES-1:0]  out_ready;
   int                chk_errors;
   int                chk_pending;
   int                chk_delivered;

   logic [31:0]       lfsr;
   logic [NODES-1:0]  accept;
   logic [7:0]        seq [NODES];
   node_t             cur_dest [NODES];
   int                pkts_left [NODES];
   int                flits_left [NODES];
   int                flit_idx [NODES];
   int                pkt_count [NODES];
   int                tb_errors;
   int                tests_run;
   logic              saw_stall;
   logic              timed_out;

   noc_mesh dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   noc_checker #(
      .SRC_LSB (SRC_LSB)
   ) chk_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .errors    (chk_errors),
      .pending   (chk_pending),
      .delivered (chk_delivered)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // mode 0 cycles all dests, 1 random, 2 hotspot, 3 next node
   task automatic load_flit(input int n, input int max_len, input int mode, input int hot);
      flit_t f;
      if (flits_left[n] == 0 && pkts_left[n] == 0) begin
         in_valid[n] = 1'b0;
         in_last[n]  = 1'b0;
      end else begin
         f = flit_t'(rand_bits(FLIT_W));
         if (flits_left[n] == 0) begin
            pkts_left[n]--;
            flits_left[n] = 1 + int'(rand_bits(2)) % max_len;
            case (mode)
               0:       cur_dest[n] = node_t'(pkt_count[n] % NODES);
               1:       cur_dest[n] = node_t'(rand_bits(NODE_W));
               2:       cur_dest[n] = node_t'(hot);
               default: cur_dest[n] = node_t'((n + 1) % NODES);
            endcase
            pkt_count[n]++;
            seq[n]      = seq[n] + 8'd1;
            flit_idx[n] = 0;
            f[DEST_MSB -: NODE_W] = cur_dest[n];
            f[SRC_LSB +: NODE_W]  = node_t'(n);
         end else begin
            f[SEQ_LSB - 1 -: 2] = 2'(flit_idx[n]);
         end
         f[SEQ_LSB +: 8] = seq[n];
         flit_idx[n]++;
         flits_left[n]--;
         in_flit[n]  = f;
         in_last[n]  = (flits_left[n] == 0);
         in_valid[n] = 1'b1;
      end
   endtask

   task automatic run_traffic(input int pkts, input int max_len, input int mode,
                              input int hot, input bit stall);
      int steps;
      for (int n = 0; n < NODES; n++) begin
         pkts_left[n]  = pkts;
         flits_left[n] = 0;
      end
      accept = '0;
      steps  = 0;
      do begin
         @(negedge clk);
         for (int n = 0; n < NODES; n++) begin
            if (accept[n] || !in_valid[n])
               load_flit(n, max_len, mode, hot);
         end
         // under back-pressure out_ready is high about one cycle in four
         out_ready = stall ? NODES'(rand_bits(NODES) & rand_bits(NODES)) : '1;
         // ready is registered, so it holds until the next rising edge
         accept = in_valid & in_ready;
         if ((in_valid & ~in_ready) != '0)
            saw_stall = 1'b1;
         steps++;
      end while (in_valid != '0 && steps < STEP_LIMIT);
      if (in_valid != '0) begin
         timed_out = 1'b1;
         $display("timeout: the sources could not inject all packets");
      end
      out_ready = '1;
      steps     = 0;
      while (!timed_out && chk_pending != 0 && steps < STEP_LIMIT) begin
         @(negedge clk);
         steps++;
      end
      if (!timed_out && chk_pending != 0) begin
         timed_out = 1'b1;
         $display("timeout: %0d flits were never delivered", chk_pending);
      end
   endtask

   task automatic run_test(input int id, input string name, input int pkts, input int max_len,
                           input int mode, input int hot, input bit stall);
      int err0;
      int flits0;
      err0      = tb_errors + chk_errors;
      flits0    = chk_delivered;
      saw_stall = 1'b0;
      run_traffic(pkts, max_len, mode, hot, stall);
      if (stall && !saw_stall && !timed_out) begin
         tb_errors++;
         $display("in_ready never fell while the outputs were stalled");
      end
      $display("test %0d %s: %0d flits, %0d errors", id, name,
               chk_delivered - flits0, tb_errors + chk_errors - err0);
      tests_run++;
   endtask

   initial begin
      arst_n    = 1'b0;
      in_flit   = '0;
      in_last   = '0;
      in_valid  = '0;
      out_ready = '1;
      lfsr      = 32'hb120f95c;
      tb_errors = 0;
      tests_run = 0;
      timed_out = 1'b0;
      for (int n = 0; n < NODES; n++) begin
         seq[n]       = '0;
         pkt_count[n] = 0;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      if (out_valid != '0) begin
         tb_errors++;
         $display("[FAIL] out_valid got %h expected %h", out_valid, {NODES{1'b0}});
      end
      if (in_ready != '1) begin
         tb_errors++;
         $display("[FAIL] in_ready got %h expected %h", in_ready, {NODES{1'b1}});
      end
      $display("test 1 reset state: %0d errors", tb_errors);
      tests_run++;

      if (!timed_out)
         run_test(2, "single-flit all pairs", 8, 1, 0, 0, 1'b0);
      if (!timed_out)
         run_test(3, "multi-flit random", 10, 4, 1, 0, 1'b0);
      if (!timed_out)
         run_test(4, "per-pair ordering", 24, 4, 3, 0, 1'b0);
      if (!timed_out)
         run_test(5, "back-pressure", 12, 4, 1, 0, 1'b1);
      if (!timed_out)
         run_test(6, "hotspot", 10, 4, 2, NODES - 1, 1'b0);

      $display("%0d tests, %0d flits delivered, %0d errors",
               tests_run, chk_delivered, tb_errors + chk_errors);
      if (tb_errors + chk_errors == 0 && !timed_out)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
